// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= mips_system_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

# the run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
common/mips_pkg.sv
design/cpu/mips_decoder.sv
design/cpu/mips_regfile.sv
design/cpu/mips_core.sv
design/avalon_ram.sv
design/mips_system.sv
bench/mips_system_tb.sv

// File: bench/mips_system_tb.sv
`default_nettype none
`timescale 1ns/1ps

module mips_system_tb
    import mips_pkg::*;
();

    localparam int                RAM_WORDS   = 256;
    localparam int                WAIT_STATES = 2;
    localparam logic [word_w-1:0] RESET_PC    = 32'h4;
    localparam int                LOAD_W      = $clog2(RAM_WORDS);
    localparam int                RANDOM_LEN  = 12;     // random instructions per program.
    localparam int                N_RANDOM    = 20;
    localparam int                N_PROGRAMS  = 3 + N_RANDOM;
    localparam int                PROG_MAX    = 16;     // longest program in words.
    localparam int                INSTR_BOUND = 20;     // most instructions any program runs.
    localparam int                PROG_CYCLES = 4 + 4 + 2 * PROG_MAX +
                                                INSTR_BOUND * (2 * WAIT_STATES + 3);
    localparam int                WATCHDOG_CYCLES = N_PROGRAMS * PROG_CYCLES + 50;

    logic              clk;
    logic              arst_n;
    logic              run;
    logic              load_valid;
    logic [LOAD_W-1:0] load_addr;
    logic [word_w-1:0] load_data;
    logic              load_ready;
    logic              active;
    logic [word_w-1:0] register_v0;

    logic [word_w-1:0] prog [$];                // program under test with word 0 first.
    logic [word_w-1:0] model_mem [RAM_WORDS];   // mirror of the ram contents.
    logic [word_w-1:0] expected_v0;
    logic              saw_busy;
    int                checks_done;
    event              program_done;

    mips_system #(
        .RAM_WORDS   (RAM_WORDS),
        .WAIT_STATES (WAIT_STATES),
        .RESET_PC    (RESET_PC)
    ) u_mips_system (
        .clk         (clk),
        .arst_n      (arst_n),
        .run         (run),
        .active      (active),
        .register_v0 (register_v0),
        .load_valid  (load_valid),
        .load_ready  (load_ready),
        .load_addr   (load_addr),
        .load_data   (load_data)
    );

    always #2 clk = ~clk;

    // sampled mid-cycle while the core owns the ram for its fetches.
    always @(negedge clk) begin
        if (active && !load_ready) begin
            saw_busy = 1'b1;
        end
    end

    function automatic logic [31:0] r_type(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                          logic [5:0] fn);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_type(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_type(logic [25:0] word_target);
        return {6'h02, word_target};
    endfunction

    // interprets model_mem from RESET_PC until jr to zero and returns $v0.
    function automatic logic [31:0] reference_v0();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] pc4;
        logic [31:0] next_pc;
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic        halted;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc     = RESET_PC;
        halted = 1'b0;
        steps  = 0;
        while (!halted && steps < INSTR_BOUND) begin
            instr   = model_mem[(pc >> 2) % RAM_WORDS];
            a       = regs[instr[25:21]];
            b       = regs[instr[20:16]];
            imm     = {{16{instr[15]}}, instr[15:0]};
            pc4     = pc + 32'd4;
            next_pc = pc4;
            case (instr[31:26])
                6'h00: begin
                    case (instr[5:0])
                        6'h21: regs[instr[15:11]] = a + b;
                        6'h23: regs[instr[15:11]] = a - b;
                        6'h24: regs[instr[15:11]] = a & b;
                        6'h25: regs[instr[15:11]] = a | b;
                        6'h2a: regs[instr[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        6'h08: begin
                            if (a == '0) begin
                                halted = 1'b1;
                            end
                            next_pc = a;
                        end
                        default: ;                          // unknown r-type is a no-op.
                    endcase
                end
                6'h09: regs[instr[20:16]] = a + imm;
                6'h23: regs[instr[20:16]] = model_mem[((a + imm) >> 2) % RAM_WORDS];
                6'h2b: model_mem[((a + imm) >> 2) % RAM_WORDS] = b;
                6'h04: next_pc = (a == b) ? pc4 + (imm << 2) : pc4;
                6'h05: next_pc = (a != b) ? pc4 + (imm << 2) : pc4;
                6'h02: next_pc = {pc4[31:28], instr[25:0], 2'b00};
                default: ;
            endcase
            regs[0] = '0;
            pc      = next_pc;
            steps++;
        end
        return regs[2];
    endfunction

    task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
        $display("** Error at %0d ns: %s expected %h, actual %h", $time, name, expected, actual);
        $display("Verification failed");
        $fatal(1, "value mismatch on %s", name);
    endtask

    task automatic report_problem(string what);
        $display("Error at %0d ns: %s", $time, what);
        $display("Verification failed");
        $fatal(1, "%s", what);
    endtask

    task automatic apply_reset();
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 arst_n = 1'b1;
    endtask

    // one word per accepted handshake and the same word into the model memory.
    task automatic load_program();
        for (int i = 0; i < prog.size(); i++) begin
            load_valid = 1'b1;
            load_addr  = LOAD_W'(i);
            load_data  = prog[i];
            while (!load_ready) begin
                @(posedge clk);
                #1;
            end
            @(posedge clk);
            #1;
            model_mem[i % RAM_WORDS] = prog[i];
        end
        load_valid = 1'b0;
    endtask

    task automatic run_program();
        apply_reset();
        assert (active === 1'b0) else report_mismatch("active", 32'd0, 32'(active));
        assert (load_ready === 1'b1) else report_mismatch("load_ready", 32'd1, 32'(load_ready));
        load_program();
        run = 1'b1;
        @(posedge clk);
        #1 run = 1'b0;
        assert (active === 1'b1) else report_mismatch("active", 32'd1, 32'(active));
        while (active) begin
            @(posedge clk);
            #1;
        end
        expected_v0 = reference_v0();
        -> program_done;
        @(posedge clk);
        #1;
    endtask

    task automatic build_random_program();
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        int          kind;
        prog.delete();
        prog.push_back(32'h0);
        for (int i = 0; i < RANDOM_LEN; i++) begin
            rs   = 5'($urandom_range(0, 7));
            rt   = 5'($urandom_range(0, 7));
            rd   = 5'($urandom_range(1, 7));
            imm  = 16'($urandom);
            kind = $urandom_range(0, 5);
            case (kind)
                0: prog.push_back(i_type(OP_ADDIU, rs, rd, imm));
                1: prog.push_back(r_type(rs, rt, rd, FN_ADDU));
                2: prog.push_back(r_type(rs, rt, rd, FN_SUBU));
                3: prog.push_back(r_type(rs, rt, rd, FN_AND));
                4: prog.push_back(r_type(rs, rt, rd, FN_OR));
                default: prog.push_back(r_type(rs, rt, rd, FN_SLT));
            endcase
        end
        prog.push_back(r_type(5'($urandom_range(1, 7)), 5'($urandom_range(1, 7)), reg_v0,
                              FN_ADDU));
        prog.push_back(r_type(5'd0, 5'd0, 5'd0, FN_JR));  // halt.
    endtask

    initial begin
        forever begin
            @(program_done);
            assert (register_v0 === expected_v0)
                else report_mismatch("register_v0", expected_v0, register_v0);
            checks_done++;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_problem("the processor never finished a program within the time limit");
    end

    initial begin
        void'($urandom(32'h2c16));
        clk         = 1'b0;
        arst_n      = 1'b0;
        run         = 1'b0;
        load_valid  = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        saw_busy    = 1'b0;
        checks_done = 0;

        // addiu chain around a branch that falls through.
        prog = '{32'h0,
                 i_type(OP_ADDIU, 5'd0, 5'd8, 16'h0050),
                 i_type(OP_BEQ, 5'd8, 5'd0, 16'h0001),
                 i_type(OP_ADDIU, 5'd8, reg_v0, 16'h0030),
                 i_type(OP_ADDIU, reg_v0, reg_v0, 16'h0020),
                 r_type(5'd0, 5'd0, 5'd0, FN_JR)};
        run_program();
        assert (saw_busy) else report_problem("load_ready never went low while the core ran");

        // taken bne, taken beq and a jump each skip one addiu.
        prog = '{32'h0,
                 i_type(OP_ADDIU, 5'd0, reg_v0, 16'h0001),
                 i_type(OP_BNE, reg_v0, 5'd0, 16'h0001),
                 i_type(OP_ADDIU, reg_v0, reg_v0, 16'h0100),
                 i_type(OP_BEQ, 5'd0, 5'd0, 16'h0001),
                 i_type(OP_ADDIU, reg_v0, reg_v0, 16'h0200),
                 j_type(26'd8),
                 i_type(OP_ADDIU, reg_v0, reg_v0, 16'h0400),
                 i_type(OP_ADDIU, reg_v0, reg_v0, 16'h0010),
                 r_type(5'd0, 5'd0, 5'd0, FN_JR)};
        run_program();

        // stores to a data area and loads back that are combined into $v0.
        prog = '{32'h0,
                 i_type(OP_ADDIU, 5'd0, 5'd8, 16'h0300),
                 i_type(OP_ADDIU, 5'd0, 5'd9, 16'h0123),
                 i_type(OP_ADDIU, 5'd0, 5'd10, 16'h0045),
                 i_type(OP_ADDIU, 5'd0, 5'd11, 16'hfff9),
                 i_type(OP_SW, 5'd8, 5'd9, 16'h0000),
                 i_type(OP_SW, 5'd8, 5'd10, 16'h0004),
                 i_type(OP_SW, 5'd8, 5'd11, 16'h0008),
                 i_type(OP_LW, 5'd8, 5'd16, 16'h0000),
                 i_type(OP_LW, 5'd8, 5'd17, 16'h0004),
                 i_type(OP_LW, 5'd8, 5'd18, 16'h0008),
                 r_type(5'd16, 5'd17, reg_v0, FN_ADDU),
                 r_type(reg_v0, 5'd18, reg_v0, FN_SUBU),
                 r_type(5'd0, 5'd0, 5'd0, FN_JR)};
        run_program();

        for (int n = 0; n < N_RANDOM; n++) begin
            build_random_program();
            run_program();
        end

        if (checks_done == N_PROGRAMS) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Verification failed");
            $fatal(1, "only %0d of %0d programs were checked", checks_done, N_PROGRAMS);
        end
    end

endmodule

`default_nettype wire

// File: common/mips_pkg.sv
`default_nettype none

package mips_pkg;

    localparam int word_w    = 32;   // data and address width.
    localparam int reg_idx_w = 5;    // register index width.

    localparam logic [reg_idx_w-1:0] reg_v0 = 5'd2;   // result register $v0.

    // primary opcodes of the kept instruction forms.
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,          // r-type, function field selects.
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // function field values under OP_SPECIAL.
    typedef enum logic [5:0] {
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,              // also the equality test for branches.
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4               // signed compare, result is 0 or 1.
    } alu_op_e;

    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,           // waiting for run.
        ST_FETCH   = 3'd1,
        ST_EXECUTE = 3'd2,
        ST_MEMORY  = 3'd3            // data access of lw and sw.
    } core_state_e;

endpackage

`default_nettype wire

// File: design/avalon_ram.sv
`default_nettype none
`timescale 1ns/1ps

module avalon_ram import mips_pkg::*; #(
    parameter int RAM_WORDS   = 256,
    parameter int WAIT_STATES = 1
) (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire [word_w-1:0]            address,
    input  wire                         read,
    input  wire                         write,
    input  wire [word_w-1:0]            writedata,
    output logic                        waitrequest,
    output logic [word_w-1:0]           readdata,
    input  wire                         load_valid,
    output logic                        load_ready,
    input  wire [$clog2(RAM_WORDS)-1:0] load_addr,
    input  wire [word_w-1:0]            load_data
);

    localparam int IDX_W = $clog2(RAM_WORDS);
    localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    logic [word_w-1:0] mem [RAM_WORDS];
    logic [IDX_W-1:0]  word_idx;
    logic [IDX_W-1:0]  load_idx;
    logic [CNT_W-1:0]  wait_cnt;
    logic              request;

    assign request = read || write;

    // byte address to word index, wrapping past the top of the array.
    assign word_idx = IDX_W'((address >> 2) % RAM_WORDS);
    assign load_idx = IDX_W'(load_addr % RAM_WORDS);

    // high from the first cycle of a request until WAIT_STATES have passed.
    assign waitrequest = request && (wait_cnt != CNT_W'(WAIT_STATES));
    assign readdata    = mem[word_idx];
    assign load_ready  = !request;       // program load only while the bus is quiet.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wait_cnt <= '0;
        end else if (waitrequest) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;              // completion or no request.
        end
    end

    always_ff @(posedge clk) begin
        if (write && !waitrequest) begin
            mem[word_idx] <= writedata;
        end else if (load_valid && load_ready) begin
            mem[load_idx] <= load_data;
        end
    end

endmodule

`default_nettype wire

// File: design/cpu/mips_core.sv
`default_nettype none
`timescale 1ns/1ps

module mips_core import mips_pkg::*; #(
    parameter logic [word_w-1:0] RESET_PC = 32'h4
) (
    input  wire                clk,
    input  wire                arst_n,
    input  wire                run,
    output logic               active,
    output logic [word_w-1:0]  address,
    output logic               read,
    output logic               write,
    output logic [word_w-1:0]  writedata,
    input  wire [word_w-1:0]   readdata,
    input  wire                waitrequest,
    output logic [word_w-1:0]  register_v0
);

    core_state_e          state;
    logic [word_w-1:0]    pc;
    logic [word_w-1:0]    ir;
    logic [word_w-1:0]    pc_plus4;
    logic [word_w-1:0]    branch_target;
    logic [word_w-1:0]    jump_addr;
    logic [word_w-1:0]    alu_b;
    logic [word_w-1:0]    alu_result;
    logic                 take_branch;
    logic                 fetch_done;
    logic                 mem_done;

    logic [reg_idx_w-1:0] rs;
    logic [reg_idx_w-1:0] rt;
    logic [reg_idx_w-1:0] rd;
    logic [word_w-1:0]    imm_ext;
    logic [25:0]          jump_target;
    alu_op_e              alu_op;
    logic                 use_imm;
    logic                 reg_write;
    logic                 write_rt;
    logic                 is_load;
    logic                 is_store;
    logic                 is_beq;
    logic                 is_bne;
    logic                 is_j;
    logic                 is_jr;
    logic                 illegal;

    logic [word_w-1:0]    rs_data;
    logic [word_w-1:0]    rt_data;
    logic                 rf_we;
    logic [reg_idx_w-1:0] rf_wa;
    logic [word_w-1:0]    rf_wd;

    mips_decoder u_decoder (
        .instr       (ir),
        .rs          (rs),
        .rt          (rt),
        .rd          (rd),
        .imm_ext     (imm_ext),
        .jump_target (jump_target),
        .alu_op      (alu_op),
        .use_imm     (use_imm),
        .reg_write   (reg_write),
        .write_rt    (write_rt),
        .is_load     (is_load),
        .is_store    (is_store),
        .is_beq      (is_beq),
        .is_bne      (is_bne),
        .is_j        (is_j),
        .is_jr       (is_jr),
        .illegal     (illegal)
    );

    mips_regfile u_regfile (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs      (rs),
        .rt      (rt),
        .we      (rf_we),
        .wa      (rf_wa),
        .wd      (rf_wd),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .v0      (register_v0)
    );

    assign alu_b = use_imm ? imm_ext : rt_data;

    always_comb begin
        case (alu_op)
            ALU_SUB: alu_result = rs_data - alu_b;
            ALU_AND: alu_result = rs_data & alu_b;
            ALU_OR:  alu_result = rs_data | alu_b;
            ALU_SLT: alu_result = {31'd0, $signed(rs_data) < $signed(alu_b)};
            default: alu_result = rs_data + alu_b;
        endcase
    end

    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};
    assign jump_addr     = {pc_plus4[31:28], jump_target, 2'b00};
    assign take_branch   = !illegal && ((is_beq && (alu_result == '0)) ||
                                        (is_bne && (alu_result != '0)));

    assign fetch_done = (state == ST_FETCH) && !waitrequest;
    assign mem_done   = (state == ST_MEMORY) && !waitrequest;

    // bus outputs follow the state, so a stall holds them unchanged.
    assign read      = (state == ST_FETCH) || ((state == ST_MEMORY) && is_load);
    assign write     = (state == ST_MEMORY) && is_store;
    assign address   = (state == ST_MEMORY) ? alu_result : pc;
    assign writedata = rt_data;
    assign active    = (state != ST_IDLE);

    // alu results land in execute, loads when the read completes.
    assign rf_we = ((state == ST_EXECUTE) && reg_write && !is_load && !illegal) ||
                   (mem_done && is_load);
    assign rf_wa = write_rt ? rt : rd;
    assign rf_wd = (state == ST_MEMORY) ? readdata : alu_result;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
            pc    <= RESET_PC;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (run) begin
                        state <= ST_FETCH;
                        pc    <= RESET_PC;   // each run starts from the entry point.
                    end
                end
                ST_FETCH: begin
                    if (!waitrequest) begin
                        state <= ST_EXECUTE;
                    end
                end
                ST_EXECUTE: begin
                    state <= ST_FETCH;
                    if (is_jr) begin
                        pc <= rs_data;
                        if (rs_data == '0) begin
                            state <= ST_IDLE;    // jr to zero ends the program.
                        end
                    end else if (is_j) begin
                        pc <= jump_addr;
                    end else if (take_branch) begin
                        pc <= branch_target;
                    end else begin
                        pc <= pc_plus4;          // illegal words fall through here.
                        if (is_load || is_store) begin
                            state <= ST_MEMORY;
                        end
                    end
                end
                ST_MEMORY: begin
                    if (!waitrequest) begin
                        state <= ST_FETCH;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_done) begin
            ir <= readdata;
        end
    end

endmodule

`default_nettype wire

// File: design/cpu/mips_decoder.sv
`default_nettype none
`timescale 1ns/1ps

module mips_decoder import mips_pkg::*; (
    input  wire [word_w-1:0]     instr,
    output logic [reg_idx_w-1:0] rs,
    output logic [reg_idx_w-1:0] rt,
    output logic [reg_idx_w-1:0] rd,
    output logic [word_w-1:0]    imm_ext,
    output logic [25:0]          jump_target,
    output alu_op_e              alu_op,
    output logic                 use_imm,
    output logic                 reg_write,
    output logic                 write_rt,
    output logic                 is_load,
    output logic                 is_store,
    output logic                 is_beq,
    output logic                 is_bne,
    output logic                 is_j,
    output logic                 is_jr,
    output logic                 illegal
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode      = instr[31:26];
    assign funct       = instr[5:0];
    assign rs          = instr[25:21];
    assign rt          = instr[20:16];
    assign rd          = instr[15:11];
    assign imm_ext     = {{16{instr[15]}}, instr[15:0]};   // sign-extended.
    assign jump_target = instr[25:0];

    always_comb begin
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        reg_write = 1'b0;
        write_rt  = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_beq    = 1'b0;
        is_bne    = 1'b0;
        is_j      = 1'b0;
        is_jr     = 1'b0;
        illegal   = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                reg_write = 1'b1;                    // all r-type forms but jr.
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_JR: begin
                        reg_write = 1'b0;
                        is_jr     = 1'b1;
                    end
                    default: begin
                        reg_write = 1'b0;
                        illegal   = 1'b1;
                    end
                endcase
            end
            OP_ADDIU: begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
                write_rt  = 1'b1;
            end
            OP_LW: begin
                use_imm   = 1'b1;                    // alu forms rs + offset.
                reg_write = 1'b1;
                write_rt  = 1'b1;
                is_load   = 1'b1;
            end
            OP_SW: begin
                use_imm  = 1'b1;
                is_store = 1'b1;
            end
            OP_BEQ: begin
                alu_op = ALU_SUB;                    // zero result means equal.
                is_beq = 1'b1;
            end
            OP_BNE: begin
                alu_op = ALU_SUB;
                is_bne = 1'b1;
            end
            OP_J:    is_j = 1'b1;
            default: illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: design/cpu/mips_regfile.sv
`default_nettype none
`timescale 1ns/1ps

module mips_regfile import mips_pkg::*; (
    input  wire                 clk,
    input  wire                 arst_n,
    input  wire [reg_idx_w-1:0] rs,
    input  wire [reg_idx_w-1:0] rt,
    input  wire                 we,
    input  wire [reg_idx_w-1:0] wa,
    input  wire [word_w-1:0]    wd,
    output logic [word_w-1:0]   rs_data,
    output logic [word_w-1:0]   rt_data,
    output logic [word_w-1:0]   v0
);

    localparam int NUM_REGS = 2 ** reg_idx_w;

    logic [word_w-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin   // $zero stays zero.
            regs[wa] <= wd;
        end
    end

    // reads are asynchronous so execute sees operands in its single cycle.
    assign rs_data = regs[rs];
    assign rt_data = regs[rt];
    assign v0      = regs[reg_v0];

endmodule

`default_nettype wire

// File: design/mips_system.sv
`default_nettype none
`timescale 1ns/1ps

module mips_system import mips_pkg::*; #(
    parameter int                RAM_WORDS   = 256,
    parameter int                WAIT_STATES = 1,
    parameter logic [word_w-1:0] RESET_PC    = 32'h4
) (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire                         run,
    output logic                        active,
    output logic [word_w-1:0]           register_v0,
    input  wire                         load_valid,
    output logic                        load_ready,
    input  wire [$clog2(RAM_WORDS)-1:0] load_addr,
    input  wire [word_w-1:0]            load_data
);

    logic [word_w-1:0] address;
    logic              read;
    logic              write;
    logic [word_w-1:0] writedata;
    logic [word_w-1:0] readdata;
    logic              waitrequest;

    mips_core #(
        .RESET_PC (RESET_PC)
    ) u_core (
        .clk         (clk),
        .arst_n      (arst_n),
        .run         (run),
        .active      (active),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .readdata    (readdata),
        .waitrequest (waitrequest),
        .register_v0 (register_v0)
    );

    avalon_ram #(
        .RAM_WORDS   (RAM_WORDS),
        .WAIT_STATES (WAIT_STATES)
    ) u_ram (
        .clk         (clk),
        .arst_n      (arst_n),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .load_valid  (load_valid),
        .load_ready  (load_ready),
        .load_addr   (load_addr),
        .load_data   (load_data)
    );

endmodule

`default_nettype wire
